//--- include/lsu_defines.svh
// fixed 32-bit little-endian data path only; the offset width must stay log2 of the byte count
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////
`define LSU_DATA_W 32  // data and address bus
`define LSU_BE_W   4   // one enable per byte lane
`define LSU_OFS_W  2   // byte offset inside a word

////////////////////////////////////////////////////////////////////////////
// reset values
////////////////////////////////////////////////////////////////////////////
`define LSU_RDATA_RST {`LSU_DATA_W{1'b0}}  // read data seen by the core after reset
`define LSU_OFS_RST   {`LSU_OFS_W{1'b0}}   // captured offset

`endif

//--- hdl/lsu_pkg.sv
// encodings match the execute-stage fields of the core and must not be renumbered
package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // access attributes from the execute stage
  ////////////////////////////////////////////////////////////////////////////

  // access size with two codes for byte
  typedef enum logic [1:0]
  {
    LSU_WORD    = 2'b00,
    LSU_HALF    = 2'b01,
    LSU_BYTE    = 2'b10,
    LSU_BYTE_HI = 2'b11   // also byte
  } lsu_size_e;

  // load extension mode
  typedef enum logic [1:0]
  {
    LSU_EXT_ZERO    = 2'b00,
    LSU_EXT_SIGN    = 2'b01,
    LSU_EXT_ONES    = 2'b10,  // upper bits forced high
    LSU_EXT_SIGN_HI = 2'b11   // also sign
  } lsu_ext_e;

  ////////////////////////////////////////////////////////////////////////////
  // request controller
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0]
  {
    LSU_IDLE,                  // nothing outstanding
    LSU_WAIT_RVALID,           // one access in flight
    LSU_WAIT_RVALID_EX_STALL,  // in flight while ex is stalled
    LSU_IDLE_EX_STALL          // done but ex still stalled
  } lsu_state_e;

endpackage

//--- hdl/lsu_req_align.sv
// purely combinational; the core flags the second part of a split access and adds 4 to operand b
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_req_align
(
  input  lsu_pkg::lsu_size_e      data_type_ex_i,        // word, half or byte
  input  logic [`LSU_DATA_W-1:0]  data_wdata_ex_i,       // store data as held in the register
  input  logic [`LSU_DATA_W-1:0]  operand_a_ex_i,        // base address
  input  logic [`LSU_DATA_W-1:0]  operand_b_ex_i,        // increment
  input  logic [`LSU_OFS_W-1:0]   data_reg_offset_ex_i,  // lane of the store data in the register
  input  logic                    addr_useincr_ex_i,     // use a + b, else a alone
  input  logic                    data_req_ex_i,
  input  logic                    data_misaligned_ex_i,  // this is the second part
  output logic [`LSU_DATA_W-1:0]  data_addr_o,
  output logic [`LSU_BE_W-1:0]    data_be_o,
  output logic [`LSU_DATA_W-1:0]  data_wdata_o,
  output logic                    data_misaligned_o,     // first part needs a second access
  output logic [`LSU_OFS_W-1:0]   addr_ofs_o             // low address bits for the load side
);

  import lsu_pkg::*;

  logic [`LSU_OFS_W-1:0] wdata_rot;  // lanes to rotate store data upwards

  // address generation
  assign data_addr_o = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_ofs_o  = data_addr_o[`LSU_OFS_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (data_type_ex_i)
      LSU_WORD:
      begin
        if (!data_misaligned_ex_i)
          data_be_o = {`LSU_BE_W{1'b1}} << addr_ofs_o;     // upper lanes from the offset
        else
          data_be_o = ~({`LSU_BE_W{1'b1}} << addr_ofs_o);  // remaining low lanes
      end
      LSU_HALF:
      begin
        if (!data_misaligned_ex_i)
          data_be_o = 4'b0011 << addr_ofs_o;  // offset 3 keeps only lane 3
        else
          data_be_o = 4'b0001;                // spill byte in lane 0
      end
      default:
        data_be_o = 4'b0001 << addr_ofs_o;    // byte, never split
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////////////////////////////////////////
  // register lane minus address lane wraps modulo 4
  assign wdata_rot = addr_ofs_o - data_reg_offset_ex_i;

  always_comb
  begin
    case (wdata_rot)
      2'd0:    data_wdata_o = data_wdata_ex_i;
      2'd1:    data_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'd2:    data_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: data_wdata_o = {data_wdata_ex_i[7:0], data_wdata_ex_i[31:8]};
    endcase
  end

  // split detection, only ever on the first part
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i)
    begin
      if (data_type_ex_i == LSU_WORD)
        data_misaligned_o = (addr_ofs_o != 2'd0);  // any nonzero offset crosses the word
      else if (data_type_ex_i == LSU_HALF)
        data_misaligned_o = (addr_ofs_o == 2'd3);  // top lane only
    end
  end

  // operands from the register file must be known by the time ex requests
  always_comb
  begin
    if (data_req_ex_i)
      a_addr_known: assert #0 (!$isunknown(data_addr_o))
        else $error("lsu request with unknown address %h", data_addr_o);
  end

endmodule

//--- hdl/lsu_load_align.sv
// attributes are taken on every grant; assumes rvalid of a split load's first part precedes its second
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_load_align
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    data_gnt_i,            // capture attributes of the access
  input  logic                    data_rvalid_i,         // read beat present
  input  logic [`LSU_DATA_W-1:0]  data_rdata_i,
  input  lsu_pkg::lsu_size_e      data_type_ex_i,
  input  lsu_pkg::lsu_ext_e       data_sign_ext_ex_i,
  input  logic                    data_we_ex_i,
  input  logic [`LSU_OFS_W-1:0]   addr_ofs_i,            // from the request side
  input  logic                    data_misaligned_ex_i,  // second part is in ex
  input  logic                    data_misaligned_i,     // first part of a split in ex
  output logic [`LSU_DATA_W-1:0]  data_rdata_ex_o
);

  import lsu_pkg::*;

  lsu_size_e              type_q;     // size of the access in flight
  lsu_ext_e               ext_q;      // extension mode in flight
  logic [`LSU_OFS_W-1:0]  ofs_q;      // byte offset in flight
  logic                   we_q;       // store in flight, no data to keep
  logic [`LSU_DATA_W-1:0] rdata_q;    // raw first beat or last extended result
  logic [`LSU_DATA_W-1:0] rdata_w;    // word view
  logic [15:0]            half_raw;
  logic [7:0]             byte_raw;
  logic [`LSU_DATA_W-1:0] rdata_ext;  // view picked by size

  function automatic logic [`LSU_DATA_W-1:0] ext_half(logic [15:0] h, lsu_ext_e mode);
    case (mode)
      LSU_EXT_ZERO: ext_half = {16'h0000, h};
      LSU_EXT_ONES: ext_half = {16'hffff, h};
      default:      ext_half = {{16{h[15]}}, h};  // both sign codes
    endcase
  endfunction

  function automatic logic [`LSU_DATA_W-1:0] ext_byte(logic [7:0] b, lsu_ext_e mode);
    case (mode)
      LSU_EXT_ZERO: ext_byte = {24'h00_0000, b};
      LSU_EXT_ONES: ext_byte = {24'hff_ffff, b};
      default:      ext_byte = {{24{b[7]}}, b};
    endcase
  endfunction

  // attributes follow the granted access
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q <= LSU_WORD;
      ext_q  <= LSU_EXT_ZERO;
      ofs_q  <= `LSU_OFS_RST;
      we_q   <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q <= data_type_ex_i;
      ext_q  <= data_sign_ext_ex_i;
      ofs_q  <= addr_ofs_i;
      we_q   <= data_we_ex_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // alignment views
  ////////////////////////////////////////////////////////////////////////////
  // new beat supplies the low bytes, held beat the high ones
  always_comb
  begin
    case (ofs_q)
      2'd0:    rdata_w = data_rdata_i;
      2'd1:    rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (ofs_q)
      2'd0:    half_raw = data_rdata_i[15:0];
      2'd1:    half_raw = data_rdata_i[23:8];
      2'd2:    half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], rdata_q[31:24]};  // split half
    endcase
  end

  assign byte_raw = data_rdata_i[{ofs_q, 3'b000} +: 8];

  always_comb
  begin
    case (type_q)
      LSU_WORD: rdata_ext = rdata_w;
      LSU_HALF: rdata_ext = ext_half(half_raw, ext_q);
      default:  rdata_ext = ext_byte(byte_raw, ext_q);
    endcase
  end

  // keep the raw beat while a split is under way
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= `LSU_RDATA_RST;
    else if (data_rvalid_i && !we_q)
    begin
      if (data_misaligned_ex_i || data_misaligned_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // bypass in the rvalid cycle

endmodule

//--- hdl/lsu_ctrl_fsm.sv
// assumes an in-order bus with one rvalid per grant; at most two accesses in flight across an edge
`timescale 1ns/1ns

module lsu_ctrl_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // ex wants an access
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic ex_valid_i,      // low while ex is stalled
  output logic data_req_o,      // only source of the bus request
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o
);

  import lsu_pkg::*;

  lsu_state_e state_q;
  lsu_state_e state_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= LSU_IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;
    case (state_q)
      LSU_IDLE:
      begin
        data_req_o = data_req_ex_i;  // passes straight through
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;  // hold ex until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? LSU_WAIT_RVALID : LSU_WAIT_RVALID_EX_STALL;
        end
      end
      LSU_WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        if (data_rvalid_i)
        begin
          // next access may go out with this rvalid
          data_req_o = data_req_ex_i;
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? LSU_WAIT_RVALID : LSU_WAIT_RVALID_EX_STALL;
            else
              state_d = LSU_IDLE;   // retry the request from idle
          end
          else
            state_d = LSU_IDLE;
        end
      end
      LSU_WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? LSU_IDLE : LSU_IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = LSU_WAIT_RVALID;  // stall gone before the data
      end
      LSU_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = LSU_IDLE;
      end
      default:
        state_d = LSU_IDLE;
    endcase
  end

  assign busy_o = (state_q != LSU_IDLE) || data_req_o;

  // memory answers the old access before it grants a new one
  a_gnt_has_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == LSU_WAIT_RVALID && data_gnt_i) |-> data_rvalid_i)
    else $error("grant in wait_rvalid without rvalid of the previous access");

  // nothing outstanding in idle
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == LSU_IDLE) |-> !data_rvalid_i)
    else $error("rvalid while the lsu is idle");

endmodule

//--- hdl/lsu_top.sv
// load/store unit for a req/gnt/rvalid data bus; split accesses are sequenced by the core
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_top
(
  input  logic                    clk,
  input  logic                    rst_n,
  // execute stage
  input  logic                    data_req_ex_i,
  input  logic                    data_we_ex_i,
  input  lsu_pkg::lsu_size_e      data_type_ex_i,
  input  lsu_pkg::lsu_ext_e       data_sign_ext_ex_i,
  input  logic [`LSU_DATA_W-1:0]  data_wdata_ex_i,
  input  logic [`LSU_OFS_W-1:0]   data_reg_offset_ex_i,
  input  logic [`LSU_DATA_W-1:0]  operand_a_ex_i,
  input  logic [`LSU_DATA_W-1:0]  operand_b_ex_i,
  input  logic                    addr_useincr_ex_i,
  input  logic                    data_misaligned_ex_i,
  input  logic                    ex_valid_i,
  output logic [`LSU_DATA_W-1:0]  data_rdata_ex_o,
  output logic                    data_misaligned_o,
  output logic                    lsu_ready_ex_o,
  output logic                    lsu_ready_wb_o,
  output logic                    busy_o,
  // data memory
  output logic                    data_req_o,
  output logic [`LSU_DATA_W-1:0]  data_addr_o,
  output logic                    data_we_o,
  output logic [`LSU_BE_W-1:0]    data_be_o,
  output logic [`LSU_DATA_W-1:0]  data_wdata_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0]  data_rdata_i
);

  logic [`LSU_OFS_W-1:0] addr_ofs;  // low address bits to the load side

  assign data_we_o = data_we_ex_i;

  lsu_req_align u_req_align
  (
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_req_ex_i        (data_req_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_addr_o          (data_addr_o),
    .data_be_o            (data_be_o),
    .data_wdata_o         (data_wdata_o),
    .data_misaligned_o    (data_misaligned_o),
    .addr_ofs_o           (addr_ofs)
  );

  lsu_load_align u_load_align
  (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_gnt_i           (data_gnt_i),
    .data_rvalid_i        (data_rvalid_i),
    .data_rdata_i         (data_rdata_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .addr_ofs_i           (addr_ofs),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

//--- tests/lsu_checker.sv
// samples DUT ports on the rising edge only; split stores are not modelled, reads the tb memory at reset
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_checker
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_ex_i,
  input  logic                    we_ex_i,
  input  lsu_pkg::lsu_size_e      type_i,
  input  lsu_pkg::lsu_ext_e       ext_i,
  input  logic [`LSU_DATA_W-1:0]  wdata_ex_i,
  input  logic [`LSU_OFS_W-1:0]   reg_ofs_i,
  input  logic [`LSU_DATA_W-1:0]  op_a_i,
  input  logic [`LSU_DATA_W-1:0]  op_b_i,
  input  logic                    useincr_i,
  input  logic                    mis_ex_i,    // second part in ex
  input  logic                    ex_valid_i,
  input  logic [`LSU_DATA_W-1:0]  rdata_ex_i,
  input  logic                    mis_i,       // dut split flag
  input  logic                    ready_ex_i,
  input  logic                    ready_wb_i,
  input  logic                    busy_i,
  input  logic                    req_i,
  input  logic [`LSU_DATA_W-1:0]  addr_i,
  input  logic [`LSU_BE_W-1:0]    be_i,
  input  logic [`LSU_DATA_W-1:0]  wdata_i,
  input  logic                    gnt_i,
  input  logic                    rvalid_i,
  output int                      err_cnt_o,
  output int                      chk_cnt_o
);

  import lsu_pkg::*;

  logic [7:0]  ref_b [0:63];  // byte copy of the memory model
  logic        pend_chk [$];  // one entry per grant, in order
  logic [31:0] pend_exp [$];
  logic [31:0] load_exp;      // result of the load in flight
  logic [31:0] hold_exp;      // last load result, held after its rvalid
  logic [31:0] exp_addr;
  logic [31:0] exp_wd;
  logic [31:0] lane_mask;
  logic [3:0]  exp_be_v;
  logic        exp_mis;
  logic        chk_now;
  logic        reset_seen = 1'b0;
  logic        hold_pend = 1'b0;  // look at the held copy next edge
  logic        stalled = 1'b0;    // granted with ex stalled
  logic        busy_chk = 1'b0;   // stall just ended
  int          n;
  int          k;

  initial
  begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  function automatic int size_bytes(lsu_size_e sz);
    case (sz)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1;
    endcase
  endfunction

  // first part takes lanes from the offset up, second part what spilled over
  function automatic logic [3:0] rule_be(int nb, logic [1:0] ofs, logic second);
    int spill;
    spill = ofs + nb - 4;
    if (second)
      return (4'b0001 << spill) - 4'b0001;
    return 4'((8'h01 << nb) - 8'h01) << ofs;
  endfunction

  function automatic logic [31:0] extend(logic [31:0] raw, int nb, lsu_ext_e m);
    logic fill;
    logic [31:0] r;
    r = raw;
    fill = (m == LSU_EXT_ZERO) ? 1'b0 : (m == LSU_EXT_ONES) ? 1'b1 : raw[8*nb-1];
    for (int i = 8 * nb; i < 32; i++)
      r[i] = fill;
    return r;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt_o++;
    if (exp !== act)
    begin
      err_cnt_o++;
      $display("mismatch %s %s: expected %h actual %h", lsu_tb.cur_name, what, exp, act);
    end
  endtask

  task automatic fail_plain(input string what);
    err_cnt_o++;
    $display("%s: %s", lsu_tb.cur_name, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (rst_n && !reset_seen)
    begin
      reset_seen = 1'b1;
      for (k = 0; k < 64; k++)
        ref_b[k] = lsu_tb.mem[k >> 2][8*(k%4) +: 8];  // snapshot of the memory fill
      check_val("reset req", 32'd0, {31'd0, req_i});
      check_val("reset ready_ex", 32'd1, {31'd0, ready_ex_i});
      check_val("reset ready_wb", 32'd1, {31'd0, ready_wb_i});
      check_val("reset busy", 32'd0, {31'd0, busy_i});
      check_val("reset rdata", 32'd0, rdata_ex_i);
    end
    else if (rst_n)
    begin
      if (hold_pend && !rvalid_i)
        check_val("rdata held", hold_exp, rdata_ex_i);  // registered copy after the bypass
      hold_pend = 1'b0;
      // older access answers first
      if (rvalid_i)
      begin
        check_val("ready_wb", 32'd1, {31'd0, ready_wb_i});  // data there for write-back
        if (pend_chk.size() == 0)
          fail_plain("rvalid arrived with no access outstanding");
        else
        begin
          chk_now = pend_chk.pop_front();
          load_exp = pend_exp.pop_front();
          if (chk_now)
          begin
            check_val("rdata", load_exp, rdata_ex_i);
            hold_exp = load_exp;
            hold_pend = 1'b1;
          end
        end
      end
      if (req_i && !req_ex_i)
        fail_plain("bus request without a request from the execute stage");
      if (req_i)
        check_val("ready_ex", {31'd0, gnt_i}, {31'd0, ready_ex_i});  // ex held until granted
      // execute stall after a grant with ex_valid low
      if (busy_chk)
      begin
        busy_chk = 1'b0;
        if (busy_i)
          fail_plain("still busy after the stall ended");
      end
      else if (stalled)
      begin
        if (ex_valid_i)
        begin
          stalled = 1'b0;
          busy_chk = 1'b1;
        end
        else if (req_i)
          fail_plain("request issued while the execute stage is stalled");
        else if (!busy_i)
          fail_plain("not busy during the execute stall");
      end
      if (req_i && gnt_i)
      begin
        n = size_bytes(type_i);
        exp_addr = useincr_i ? op_a_i + op_b_i : op_a_i;
        exp_be_v = rule_be(n, exp_addr[1:0], mis_ex_i);
        exp_mis = !mis_ex_i && (exp_addr[1:0] + n > 4);  // crosses into the next word
        check_val("addr", exp_addr, addr_i);
        check_val("be", {28'd0, exp_be_v}, {28'd0, be_i});
        check_val("misaligned", {31'd0, exp_mis}, {31'd0, mis_i});
        if (we_ex_i)
        begin
          exp_wd = 32'd0;
          lane_mask = 32'd0;
          for (k = 0; k < 4; k++)
          begin
            if (exp_be_v[k])
            begin
              exp_wd[8*k +: 8] = wdata_ex_i[8*((k - exp_addr[1:0] + reg_ofs_i) % 4) +: 8];
              lane_mask[8*k +: 8] = 8'hff;
            end
          end
          check_val("wdata", exp_wd, wdata_i & lane_mask);
          for (k = 0; k < n; k++)
            ref_b[(exp_addr + k) % 64] = wdata_ex_i[8*((reg_ofs_i + k) % 4) +: 8];
          pend_chk.push_back(1'b0);
          pend_exp.push_back(32'd0);
        end
        else
        begin
          if (!mis_ex_i)
          begin
            load_exp = 32'd0;
            for (k = 0; k < n; k++)
              load_exp[8*k +: 8] = ref_b[(exp_addr + k) % 64];
            load_exp = extend(load_exp, n, ext_i);
          end
          pend_chk.push_back(mis_ex_i || !exp_mis);  // only the last part returns the value
          pend_exp.push_back(load_exp);
        end
        if (!ex_valid_i)
          stalled = 1'b1;
      end
    end
  end

endmodule

//--- tests/lsu_tb.sv
// 16-word memory wraps on address bits 5:2; split stores are not exercised
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int          MEM_WORDS     = 16;
  localparam int          N_MAX         = 24;
  localparam int          MAX_GNT_DELAY = 2;
  localparam logic [31:0] SEED          = 32'ha9a7;

  logic clk = 1'b0;
  logic rst_n;
  logic data_req_ex_i;
  logic data_we_ex_i;
  logic addr_useincr_ex_i;
  logic data_misaligned_ex_i;
  logic ex_valid_i;
  lsu_size_e data_type_ex_i;
  lsu_ext_e  data_sign_ext_ex_i;
  logic [31:0] data_wdata_ex_i;
  logic [31:0] operand_a_ex_i;
  logic [31:0] operand_b_ex_i;
  logic [1:0]  data_reg_offset_ex_i;
  logic [31:0] data_rdata_ex_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i;
  logic data_misaligned_o;
  logic lsu_ready_ex_o;
  logic lsu_ready_wb_o;
  logic busy_o;
  logic data_req_o;
  logic data_we_o;
  logic data_gnt_i;
  logic data_rvalid_i;
  logic [3:0] data_be_o;
  int err_cnt;
  int chk_cnt;

  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] lcg_state = SEED;
  int          wait_cnt = 0;    // cycles the current request waited
  int          gnt_delay = 0;
  logic        m_acc;
  logic        m_req;
  logic        m_we;
  logic [31:0] m_addr;
  logic [31:0] m_wd;
  logic [3:0]  m_be;
  int          kk;

  // stimulus table
  string       t_name [N_MAX];
  logic        t_we [N_MAX];
  logic        t_inc [N_MAX];
  logic        t_mis [N_MAX];
  logic        t_stall [N_MAX];
  lsu_size_e   t_size [N_MAX];
  lsu_ext_e    t_ext [N_MAX];
  logic [31:0] t_a [N_MAX];
  logic [31:0] t_b [N_MAX];
  logic [31:0] t_wd [N_MAX];
  logic [1:0]  t_reg [N_MAX];
  int          n_tests = 0;
  int          n_failed = 0;
  string       cur_name = "reset";

  always #5 clk = ~clk;

  lsu_top UUT (.*);

  lsu_checker u_checker
  (
    .clk (clk), .rst_n (rst_n), .req_ex_i (data_req_ex_i), .we_ex_i (data_we_ex_i),
    .type_i (data_type_ex_i), .ext_i (data_sign_ext_ex_i), .wdata_ex_i (data_wdata_ex_i),
    .reg_ofs_i (data_reg_offset_ex_i), .op_a_i (operand_a_ex_i), .op_b_i (operand_b_ex_i),
    .useincr_i (addr_useincr_ex_i), .mis_ex_i (data_misaligned_ex_i), .ex_valid_i (ex_valid_i),
    .rdata_ex_i (data_rdata_ex_o), .mis_i (data_misaligned_o), .ready_ex_i (lsu_ready_ex_o),
    .ready_wb_i (lsu_ready_wb_o), .busy_i (busy_o), .req_i (data_req_o), .addr_i (data_addr_o),
    .be_i (data_be_o), .wdata_i (data_wdata_o), .gnt_i (data_gnt_i), .rvalid_i (data_rvalid_i),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // low bits of an lcg cycle too quickly
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////
  assign data_gnt_i = data_req_o && (wait_cnt >= gnt_delay);

  always @(posedge clk)
  begin
    m_acc = data_req_o && data_gnt_i;  // values of the cycle just ended
    m_req = data_req_o;
    m_we = data_we_o;
    m_addr = data_addr_o;
    m_be = data_be_o;
    m_wd = data_wdata_o;
    #1;
    data_rvalid_i = 1'b0;
    data_rdata_i = 32'd0;
    if (!rst_n)
      wait_cnt = 0;
    else if (m_acc)
    begin
      for (kk = 0; kk < 4; kk++)
        if (m_we && m_be[kk])
          mem[m_addr[5:2]][8*kk +: 8] = m_wd[8*kk +: 8];
      if (!m_we)
        data_rdata_i = mem[m_addr[5:2]];
      data_rvalid_i = 1'b1;  // always the cycle after the grant
      wait_cnt = 0;
      gnt_delay = next_rand() % (MAX_GNT_DELAY + 1);
    end
    else if (m_req)
      wait_cnt++;
  end

  task automatic add_test(input string nm, input logic we, input lsu_size_e sz,
                          input lsu_ext_e ext, input logic [31:0] a, input logic [31:0] b,
                          input logic inc, input logic [31:0] wd, input logic [1:0] rg,
                          input logic mis, input logic stall);
    t_name[n_tests] = nm;
    t_we[n_tests] = we;
    t_size[n_tests] = sz;
    t_ext[n_tests] = ext;
    t_a[n_tests] = a;
    t_b[n_tests] = b;
    t_inc[n_tests] = inc;
    t_wd[n_tests] = wd;
    t_reg[n_tests] = rg;
    t_mis[n_tests] = mis;
    t_stall[n_tests] = stall;
    n_tests++;
  endtask

  task automatic drive(input int i, input logic second);
    data_req_ex_i = 1'b1;
    data_we_ex_i = t_we[i];
    data_type_ex_i = t_size[i];
    data_sign_ext_ex_i = t_ext[i];
    operand_a_ex_i = t_a[i];
    operand_b_ex_i = second ? t_b[i] + 32'd4 : t_b[i];  // next word for the second part
    addr_useincr_ex_i = t_inc[i];
    data_wdata_ex_i = t_wd[i];
    data_reg_offset_ex_i = t_reg[i];
    data_misaligned_ex_i = second;
    ex_valid_i = !t_stall[i];
  endtask

  task automatic wait_grant();
    do
      @(posedge clk);
    while (!(data_req_o && data_gnt_i));
    #1;
  endtask

  task automatic wait_rvalid();
    do
      @(posedge clk);
    while (!data_rvalid_i);
    #1;
  endtask

  task automatic run_test(input int i);
    int errs_before;
    errs_before = err_cnt;
    cur_name = t_name[i];
    drive(i, 1'b0);
    wait_grant();
    if (t_mis[i])
    begin
      drive(i, 1'b1);  // goes out together with the first rvalid
      wait_grant();
    end
    if (t_stall[i])
    begin
      wait_rvalid();
      repeat (2) @(posedge clk);  // req still pending, must not go out
      #1;
      data_req_ex_i = 1'b0;
      ex_valid_i = 1'b1;
    end
    else
    begin
      data_req_ex_i = 1'b0;
      data_misaligned_ex_i = 1'b0;
      wait_rvalid();
    end
    repeat (2) @(posedge clk);
    #1;
    if (err_cnt == errs_before)
      $display("test %s ok", cur_name);
    else
    begin
      n_failed++;
      $display("test %s failed with %0d errors", cur_name, err_cnt - errs_before);
    end
  endtask

  // watchdog allows 20 cycles per entry plus reset
  initial
  begin
    #1;
    repeat (n_tests * 20 + 3 + 2) @(posedge clk);
    $display("watchdog: the DUT stopped answering before all tests finished");
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    rst_n = 1'b0;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = LSU_WORD;
    data_sign_ext_ex_i = LSU_EXT_ZERO;
    data_wdata_ex_i = 32'd0;
    data_reg_offset_ex_i = 2'd0;
    operand_a_ex_i = 32'd0;
    operand_b_ex_i = 32'd0;
    addr_useincr_ex_i = 1'b1;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i = 1'b1;
    data_rvalid_i = 1'b0;
    data_rdata_i = 32'd0;
    for (kk = 0; kk < MEM_WORDS * 4; kk++)
      mem[kk >> 2][8*(kk%4) +: 8] = kk * 37 + 129;  // every byte address differs
    //       name        we  size      ext              a      b      inc wdata        rg mis stl
    add_test("sw_word",    1, LSU_WORD, LSU_EXT_ZERO,    32'd8,  32'd4, 1, 32'hdeadbeef, 0, 0, 0);
    add_test("lw_noincr",  0, LSU_WORD, LSU_EXT_ZERO,    32'd12, 32'd9, 0, 32'd0,        0, 0, 0);
    add_test("sb_ofs1",    1, LSU_BYTE, LSU_EXT_ZERO,    32'd16, 32'd1, 1, 32'h000000c3, 0, 0, 0);
    add_test("sb_ofs3_r2", 1, LSU_BYTE_HI, LSU_EXT_ZERO, 32'd16, 32'd3, 1, 32'h00a50000, 2, 0, 0);
    add_test("sh_ofs2_r1", 1, LSU_HALF, LSU_EXT_ZERO,    32'd20, 32'd2, 1, 32'h00123400, 1, 0, 0);
    add_test("sh_ofs0",    1, LSU_HALF, LSU_EXT_ZERO,    32'd20, 32'd0, 1, 32'h00008765, 0, 0, 0);
    add_test("lw_merge16", 0, LSU_WORD, LSU_EXT_ZERO,    32'd16, 32'd0, 1, 32'd0,        0, 0, 0);
    add_test("lw_merge20", 0, LSU_WORD, LSU_EXT_ZERO,    32'd20, 32'd0, 1, 32'd0,        0, 0, 0);
    add_test("lb_zero",    0, LSU_BYTE, LSU_EXT_ZERO,    32'd16, 32'd3, 1, 32'd0,        0, 0, 0);
    add_test("lb_sign",    0, LSU_BYTE, LSU_EXT_SIGN,    32'd19, 32'd0, 0, 32'd0,        0, 0, 0);
    add_test("lb_sign_pos", 0, LSU_BYTE_HI, LSU_EXT_SIGN_HI, 32'd18, 32'd0, 1, 32'd0,   0, 0, 0);
    add_test("lb_ones",    0, LSU_BYTE, LSU_EXT_ONES,    32'd17, 32'd0, 1, 32'd0,        0, 0, 0);
    add_test("lh_sign",    0, LSU_HALF, LSU_EXT_SIGN,    32'd20, 32'd0, 1, 32'd0,        0, 0, 0);
    add_test("lh_zero",    0, LSU_HALF, LSU_EXT_ZERO,    32'd20, 32'd2, 1, 32'd0,        0, 0, 0);
    add_test("lh_ones",    0, LSU_HALF, LSU_EXT_ONES,    32'd20, 32'd2, 1, 32'd0,        0, 0, 0);
    add_test("lh_sign_hi", 0, LSU_HALF, LSU_EXT_SIGN_HI, 32'd20, 32'd2, 1, 32'd0,        0, 0, 0);
    add_test("lw_mis1",    0, LSU_WORD, LSU_EXT_ZERO,    32'd4,  32'd1, 1, 32'd0,        0, 1, 0);
    add_test("lw_mis2",    0, LSU_WORD, LSU_EXT_ZERO,    32'd4,  32'd2, 1, 32'd0,        0, 1, 0);
    add_test("lw_mis3",    0, LSU_WORD, LSU_EXT_ZERO,    32'd4,  32'd3, 1, 32'd0,        0, 1, 0);
    add_test("lh_mis3",    0, LSU_HALF, LSU_EXT_SIGN,    32'd40, 32'd3, 1, 32'd0,        0, 1, 0);
    add_test("lw_stall",   0, LSU_WORD, LSU_EXT_ZERO,    32'd12, 32'd0, 1, 32'd0,        0, 0, 1);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);  // idle outputs are sampled here
    #1;
    for (int i = 0; i < n_tests; i++)
      run_test(i);
    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, chk_cnt, err_cnt);
    if (err_cnt == 0 && n_failed == 0 && chk_cnt > 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_req_align.sv
hdl/lsu_load_align.sv
hdl/lsu_ctrl_fsm.sv
hdl/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv
